// ==== hw/dtw_accel_pkg.sv ====
// Shared types and constants; reference memory is cut to 1024 samples and only channel 0 loads
`default_nettype none

package dtw_accel_pkg;

    // Bus widths
    localparam int AXI_ADDR_W = 16;
    localparam int AXI_DATA_W = 32;
    localparam int REG_IDX_LSB = 2;
    localparam int REG_IDX_W = 4;

    // Reference memory and source stream
    localparam int REF_SAMPLE_W = 16;
    localparam int REF_PTR_W = 10;
    localparam int REF_DEPTH = 1 << REF_PTR_W;
    localparam int SRC_FIFO_DEPTH = 4;
    localparam int SRC_FIFO_PTR_W = $clog2(SRC_FIFO_DEPTH);
    localparam int AXIS_DEST_W = 4;
    localparam logic [AXIS_DEST_W-1:0] REF_STREAM_DEST = '0;

    // Major 1, minor 0, revision 0
    localparam logic [AXI_DATA_W-1:0] DTW_VERSION = 32'h1000_0000;
    localparam logic [AXI_DATA_W-1:0] DTW_KEY = 32'h0ca7_cafe;

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;
    localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

    // Register word indices taken from byte address bits 5:2
    typedef enum logic [REG_IDX_W-1:0] {
        REG_CONTROL  = 4'd0,
        REG_STATUS   = 4'd1,
        REG_REF_LEN  = 4'd2,
        REG_VERSION  = 4'd3,
        REG_KEY      = 4'd4,
        REG_REF_ADDR = 4'd5,
        REG_REF_DOUT = 4'd7
    } reg_addr_e;

    typedef enum logic [1:0] {
        LDR_IDLE,
        LDR_LOAD,
        LDR_DONE
    } loader_state_e;

    typedef struct packed {
        logic                  wr;
        logic                  rd;
        logic [REG_IDX_W-1:0]  idx;
        logic [AXI_DATA_W-1:0] wdata;
    } reg_req_t;

    typedef struct packed {
        logic                  ack;
        logic                  err;
        logic [AXI_DATA_W-1:0] rdata;
    } reg_rsp_t;

    typedef struct packed {
        logic                   tvalid;
        logic [AXIS_DEST_W-1:0] tdest;
        logic [AXI_DATA_W-1:0]  tdata;
    } src_beat_t;

    // Control bit 1 is run and bit 0 is core reset
    typedef struct packed {
        logic run;
        logic core_rst;
    } ctrl_t;

    typedef struct packed {
        logic fifo_full;
        logic fifo_empty;
        logic loader_busy;
        logic load_done;
    } status_t;

endpackage

`default_nettype wire

// ==== hw/axi_lite_reg_slave.sv ====
// AXI4-Lite slave with one outstanding write and one outstanding read; no burst or wstrb support
`default_nettype none
`timescale 1ns/1ns

module axi_lite_reg_slave
    import dtw_accel_pkg::*;
(
    input  wire                   i_S_AXI_clk,
    input  wire                   i_w_axi_rst,

    input  wire                   i_awvalid,
    input  wire  [AXI_ADDR_W-1:0] i_awaddr,
    output logic                  o_awready,
    input  wire                   i_wvalid,
    input  wire  [AXI_DATA_W-1:0] i_wdata,
    output logic                  o_wready,

    output logic                  o_bvalid,
    input  wire                   i_bready,
    output logic [1:0]            o_bresp,

    input  wire                   i_arvalid,
    input  wire  [AXI_ADDR_W-1:0] i_araddr,
    output logic                  o_arready,

    output logic                  o_rvalid,
    input  wire                   i_rready,
    output logic [1:0]            o_rresp,
    output logic [AXI_DATA_W-1:0] o_rdata,

    output reg_req_t              o_reg_req,
    input  wire reg_rsp_t         i_reg_rsp
);

    logic                  w_wr_hs;
    logic                  w_rd_hs;
    logic                  r_wr_pend;
    logic                  r_rd_pend;
    logic                  r_wr_ack_due;
    logic                  r_rd_ack_due;
    logic                  r_bvalid;
    logic                  r_rvalid;
    logic [1:0]            r_bresp;
    logic [1:0]            r_rresp;
    logic [AXI_DATA_W-1:0] r_rdata;
    reg_req_t              r_req;

    // AW and W are taken together
    assign w_wr_hs = i_awvalid && i_wvalid && !r_wr_pend;
    // A write wins when both arrive in the same cycle, since the register file takes one request
    assign w_rd_hs = i_arvalid && !r_rd_pend && !w_wr_hs;

    assign o_awready = w_wr_hs;
    assign o_wready  = w_wr_hs;
    assign o_arready = w_rd_hs;

    assign o_bvalid  = r_bvalid;
    assign o_bresp   = r_bresp;
    assign o_rvalid  = r_rvalid;
    assign o_rresp   = r_rresp;
    assign o_rdata   = r_rdata;
    assign o_reg_req = r_req;

    always_ff @(posedge i_S_AXI_clk) begin
        r_req.idx   <= w_wr_hs ? i_awaddr[REG_IDX_LSB +: REG_IDX_W]
                               : i_araddr[REG_IDX_LSB +: REG_IDX_W];
        r_req.wdata <= i_wdata;

        if (i_w_axi_rst) begin
            r_req.wr     <= 1'b0;
            r_req.rd     <= 1'b0;
            r_wr_pend    <= 1'b0;
            r_rd_pend    <= 1'b0;
            r_wr_ack_due <= 1'b0;
            r_rd_ack_due <= 1'b0;
            r_bvalid     <= 1'b0;
            r_rvalid     <= 1'b0;
        end else begin
            r_req.wr <= w_wr_hs;
            r_req.rd <= w_rd_hs;

            // Ack comes exactly one cycle after the strobe
            r_wr_ack_due <= r_req.wr;
            r_rd_ack_due <= r_req.rd;

            if (w_wr_hs) begin
                r_wr_pend <= 1'b1;
            end else if (r_bvalid && i_bready) begin
                r_wr_pend <= 1'b0;
            end

            if (w_rd_hs) begin
                r_rd_pend <= 1'b1;
            end else if (r_rvalid && i_rready) begin
                r_rd_pend <= 1'b0;
            end

            if (i_reg_rsp.ack && r_wr_ack_due) begin
                r_bvalid <= 1'b1;
            end else if (i_bready) begin
                r_bvalid <= 1'b0;
            end

            if (i_reg_rsp.ack && r_rd_ack_due) begin
                r_rvalid <= 1'b1;
            end else if (i_rready) begin
                r_rvalid <= 1'b0;
            end
        end
    end

    // Response payload
    always_ff @(posedge i_S_AXI_clk) begin
        if (i_reg_rsp.ack && r_wr_ack_due) begin
            r_bresp <= i_reg_rsp.err ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
        end
        if (i_reg_rsp.ack && r_rd_ack_due) begin
            r_rresp <= i_reg_rsp.err ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
            r_rdata <= i_reg_rsp.rdata;
        end
    end

endmodule

`default_nettype wire

// ==== hw/dtw_reg_file.sv ====
// Register map; answers every request one cycle later and unknown indices give an error and read 0
`default_nettype none
`timescale 1ns/1ns

module dtw_reg_file
    import dtw_accel_pkg::*;
(
    input  wire                     i_S_AXI_clk,
    input  wire                     i_w_axi_rst,

    input  wire reg_req_t           i_reg_req,
    output reg_rsp_t                o_reg_rsp,

    output ctrl_t                   o_ctrl,
    output logic [REF_PTR_W:0]      o_ref_len,

    output logic [REF_PTR_W-1:0]    o_dbg_ref_addr,
    input  wire  [REF_SAMPLE_W-1:0] i_dbg_ref_dout,

    input  wire loader_state_e      i_loader_state,
    input  wire                     i_fifo_empty,
    input  wire                     i_fifo_full
);

    ctrl_t                 r_ctrl;
    logic [REF_PTR_W:0]    r_ref_len;
    logic [REF_PTR_W-1:0]  r_dbg_addr;
    reg_rsp_t              r_rsp;
    status_t               w_status;
    logic                  w_idx_known;
    logic [AXI_DATA_W-1:0] w_rd_data;

    assign w_status.load_done   = (i_loader_state == LDR_DONE);
    assign w_status.loader_busy = (i_loader_state == LDR_LOAD);
    assign w_status.fifo_empty  = i_fifo_empty;
    assign w_status.fifo_full   = i_fifo_full;

    assign o_ctrl         = r_ctrl;
    assign o_ref_len      = r_ref_len;
    assign o_dbg_ref_addr = r_dbg_addr;
    assign o_reg_rsp      = r_rsp;

    // Read mux with narrower fields zero-extended
    always_comb begin
        w_idx_known = 1'b1;
        w_rd_data   = '0;
        case (i_reg_req.idx)
            REG_CONTROL:  w_rd_data = AXI_DATA_W'(r_ctrl);
            REG_STATUS:   w_rd_data = AXI_DATA_W'(w_status);
            REG_REF_LEN:  w_rd_data = AXI_DATA_W'(r_ref_len);
            REG_VERSION:  w_rd_data = DTW_VERSION;
            REG_KEY:      w_rd_data = DTW_KEY;
            REG_REF_ADDR: w_rd_data = AXI_DATA_W'(r_dbg_addr);
            REG_REF_DOUT: w_rd_data = AXI_DATA_W'(i_dbg_ref_dout);
            default:      w_idx_known = 1'b0;
        endcase
    end

    always_ff @(posedge i_S_AXI_clk) begin
        if (i_reg_req.rd) begin
            r_rsp.rdata <= w_rd_data;
        end

        if (i_w_axi_rst) begin
            r_ctrl     <= '0;
            r_ref_len  <= '0;
            r_dbg_addr <= '0;
            r_rsp.ack  <= 1'b0;
            r_rsp.err  <= 1'b0;
        end else begin
            r_rsp.ack <= i_reg_req.wr || i_reg_req.rd;
            r_rsp.err <= (i_reg_req.wr || i_reg_req.rd) && !w_idx_known;

            // Read-only words accept the write and keep their value
            if (i_reg_req.wr) begin
                case (i_reg_req.idx)
                    REG_CONTROL:  r_ctrl     <= i_reg_req.wdata[$bits(ctrl_t)-1:0];
                    REG_REF_LEN:  r_ref_len  <= i_reg_req.wdata[REF_PTR_W:0];
                    REG_REF_ADDR: r_dbg_addr <= i_reg_req.wdata[REF_PTR_W-1:0];
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/src_stream_fifo.sv ====
// Source stream filter and FIFO; only the low sample bits of channel 0 beats are kept
`default_nettype none
`timescale 1ns/1ns

module src_stream_fifo
    import dtw_accel_pkg::*;
(
    input  wire                     i_S_AXI_clk,
    input  wire                     i_w_axi_rst,

    input  wire src_beat_t          i_src,
    output logic                    o_src_tready,

    input  wire                     i_clear,
    input  wire                     i_rd_stb,

    output logic [REF_SAMPLE_W-1:0] o_rd_data,
    output logic                    o_empty,
    output logic                    o_full
);

    logic [REF_SAMPLE_W-1:0]   r_buf [SRC_FIFO_DEPTH];
    logic [SRC_FIFO_PTR_W-1:0] r_wr_ptr;
    logic [SRC_FIFO_PTR_W-1:0] r_rd_ptr;
    logic [SRC_FIFO_PTR_W:0]   r_count;
    logic                      w_accept;
    logic                      w_push;
    logic                      w_pop;

    assign o_full       = (r_count == (SRC_FIFO_PTR_W + 1)'(SRC_FIFO_DEPTH));
    assign o_empty      = (r_count == '0);
    assign o_src_tready = !o_full;

    // Beats for other channels are taken and dropped
    assign w_accept = i_src.tvalid && o_src_tready;
    assign w_push   = w_accept && (i_src.tdest == REF_STREAM_DEST);
    assign w_pop    = i_rd_stb && !o_empty;

    // Head of queue is valid before the pop
    assign o_rd_data = r_buf[r_rd_ptr];

    always_ff @(posedge i_S_AXI_clk) begin
        if (i_w_axi_rst || i_clear) begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
            r_count  <= '0;
        end else begin
            if (w_push) begin
                r_wr_ptr <= r_wr_ptr + 1'b1;
            end
            if (w_pop) begin
                r_rd_ptr <= r_rd_ptr + 1'b1;
            end
            if (w_push && !w_pop) begin
                r_count <= r_count + 1'b1;
            end else if (w_pop && !w_push) begin
                r_count <= r_count - 1'b1;
            end
        end
    end

    always_ff @(posedge i_S_AXI_clk) begin
        if (w_push) begin
            r_buf[r_wr_ptr] <= i_src.tdata[REF_SAMPLE_W-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== hw/ref_mem_loader.sv ====
// Reference loader; core_rst returns it to idle and clears the FIFO but keeps the memory contents
`default_nettype none
`timescale 1ns/1ns

module ref_mem_loader
    import dtw_accel_pkg::*;
(
    input  wire                     i_S_AXI_clk,
    input  wire                     i_w_axi_rst,

    input  wire ctrl_t              i_ctrl,
    input  wire  [REF_PTR_W:0]      i_ref_len,

    input  wire                     i_fifo_empty,
    input  wire  [REF_SAMPLE_W-1:0] i_fifo_data,
    output logic                    o_fifo_rd_stb,
    output logic                    o_fifo_clear,

    input  wire  [REF_PTR_W-1:0]    i_dbg_addr,
    output logic [REF_SAMPLE_W-1:0] o_dbg_dout,

    output loader_state_e           o_state
);

    logic [REF_SAMPLE_W-1:0] r_ref_mem [REF_DEPTH];
    logic [REF_SAMPLE_W-1:0] r_dbg_dout;
    logic [REF_PTR_W:0]      r_wr_cnt;
    loader_state_e           r_state;
    logic                    w_load;

    // One sample per cycle while the FIFO has data
    assign w_load = (r_state == LDR_LOAD) && !i_fifo_empty;

    assign o_fifo_rd_stb = w_load;
    assign o_fifo_clear  = i_ctrl.core_rst;
    assign o_dbg_dout    = r_dbg_dout;
    assign o_state       = r_state;

    always_ff @(posedge i_S_AXI_clk) begin
        if (i_w_axi_rst || i_ctrl.core_rst) begin
            r_state  <= LDR_IDLE;
            r_wr_cnt <= '0;
        end else begin
            case (r_state)
                LDR_IDLE: begin
                    if (i_ctrl.run) begin
                        r_wr_cnt <= '0;
                        // Zero length finishes without touching the FIFO
                        r_state  <= (i_ref_len == '0) ? LDR_DONE : LDR_LOAD;
                    end
                end
                LDR_LOAD: begin
                    if (w_load) begin
                        r_wr_cnt <= r_wr_cnt + 1'b1;
                        if (r_wr_cnt + 1'b1 == i_ref_len) begin
                            r_state <= LDR_DONE;
                        end
                    end
                end
                LDR_DONE: begin
                    // Held until core_rst
                end
                default: begin
                    r_state <= LDR_IDLE;
                end
            endcase
        end
    end

    // Write port from the FIFO to addresses 0 upward
    always_ff @(posedge i_S_AXI_clk) begin
        if (w_load) begin
            r_ref_mem[r_wr_cnt[REF_PTR_W-1:0]] <= i_fifo_data;
        end
    end

    // Registered debug read port
    always_ff @(posedge i_S_AXI_clk) begin
        r_dbg_dout <= r_ref_mem[i_dbg_addr];
    end

endmodule

`default_nettype wire

// ==== hw/dtw_accel.sv ====
// Accelerator host side top; assumes a single clock domain for the AXI4-Lite and stream ports
`default_nettype none
`timescale 1ns/1ns

module dtw_accel
    import dtw_accel_pkg::*;
(
    input  wire                   i_S_AXI_clk,
    input  wire                   i_w_axi_rst,

    input  wire                   i_awvalid,
    input  wire  [AXI_ADDR_W-1:0] i_awaddr,
    output logic                  o_awready,
    input  wire                   i_wvalid,
    input  wire  [AXI_DATA_W-1:0] i_wdata,
    output logic                  o_wready,
    output logic                  o_bvalid,
    input  wire                   i_bready,
    output logic [1:0]            o_bresp,
    input  wire                   i_arvalid,
    input  wire  [AXI_ADDR_W-1:0] i_araddr,
    output logic                  o_arready,
    output logic                  o_rvalid,
    input  wire                   i_rready,
    output logic [1:0]            o_rresp,
    output logic [AXI_DATA_W-1:0] o_rdata,

    input  wire src_beat_t        i_src,
    output logic                  o_src_tready
);

    reg_req_t                w_reg_req;
    reg_rsp_t                w_reg_rsp;
    ctrl_t                   w_ctrl;
    logic [REF_PTR_W:0]      w_ref_len;
    logic [REF_PTR_W-1:0]    w_dbg_ref_addr;
    logic [REF_SAMPLE_W-1:0] w_dbg_ref_dout;
    loader_state_e           w_loader_state;
    logic                    w_fifo_empty;
    logic                    w_fifo_full;
    logic                    w_fifo_clear;
    logic                    w_fifo_rd_stb;
    logic [REF_SAMPLE_W-1:0] w_fifo_data;

    axi_lite_reg_slave axi_slave0 (
        .i_S_AXI_clk (i_S_AXI_clk),
        .i_w_axi_rst (i_w_axi_rst),
        .i_awvalid   (i_awvalid),
        .i_awaddr    (i_awaddr),
        .o_awready   (o_awready),
        .i_wvalid    (i_wvalid),
        .i_wdata     (i_wdata),
        .o_wready    (o_wready),
        .o_bvalid    (o_bvalid),
        .i_bready    (i_bready),
        .o_bresp     (o_bresp),
        .i_arvalid   (i_arvalid),
        .i_araddr    (i_araddr),
        .o_arready   (o_arready),
        .o_rvalid    (o_rvalid),
        .i_rready    (i_rready),
        .o_rresp     (o_rresp),
        .o_rdata     (o_rdata),
        .o_reg_req   (w_reg_req),
        .i_reg_rsp   (w_reg_rsp)
    );

    dtw_reg_file reg_file0 (
        .i_S_AXI_clk    (i_S_AXI_clk),
        .i_w_axi_rst    (i_w_axi_rst),
        .i_reg_req      (w_reg_req),
        .o_reg_rsp      (w_reg_rsp),
        .o_ctrl         (w_ctrl),
        .o_ref_len      (w_ref_len),
        .o_dbg_ref_addr (w_dbg_ref_addr),
        .i_dbg_ref_dout (w_dbg_ref_dout),
        .i_loader_state (w_loader_state),
        .i_fifo_empty   (w_fifo_empty),
        .i_fifo_full    (w_fifo_full)
    );

    src_stream_fifo src_fifo0 (
        .i_S_AXI_clk  (i_S_AXI_clk),
        .i_w_axi_rst  (i_w_axi_rst),
        .i_src        (i_src),
        .o_src_tready (o_src_tready),
        .i_clear      (w_fifo_clear),
        .i_rd_stb     (w_fifo_rd_stb),
        .o_rd_data    (w_fifo_data),
        .o_empty      (w_fifo_empty),
        .o_full       (w_fifo_full)
    );

    ref_mem_loader loader0 (
        .i_S_AXI_clk   (i_S_AXI_clk),
        .i_w_axi_rst   (i_w_axi_rst),
        .i_ctrl        (w_ctrl),
        .i_ref_len     (w_ref_len),
        .i_fifo_empty  (w_fifo_empty),
        .i_fifo_data   (w_fifo_data),
        .o_fifo_rd_stb (w_fifo_rd_stb),
        .o_fifo_clear  (w_fifo_clear),
        .i_dbg_addr    (w_dbg_ref_addr),
        .o_dbg_dout    (w_dbg_ref_dout),
        .o_state       (w_loader_state)
    );

endmodule

`default_nettype wire

// ==== verif/dtw_accel_tests.svh ====
// Directed tests included inside tb_dtw_accel; they run in order and share DUT state
`ifndef DTW_ACCEL_TESTS_SVH
`define DTW_ACCEL_TESTS_SVH

task automatic verify_identity();
    logic [AXI_DATA_W-1:0] data;
    test_name = "identification";
    read_reg(REG_VERSION, data);
    check_word("version", 32'h1000_0000, data);
    read_reg(REG_KEY, data);
    check_word("key", 32'h0ca7_cafe, data);
endtask

task automatic register_access();
    logic [AXI_DATA_W-1:0] data;
    logic [3:0]            bad_idx [2];
    test_name = "registers";
    bad_idx[0] = 4'd6;
    bad_idx[1] = 4'd12;
    // Values right after reset
    expect_status(1'b0, 1'b0, 1'b1, 1'b0);
    read_reg(REG_CONTROL, data);
    check_word("control after reset", 32'h0, data);
    read_reg(REG_REF_LEN, data);
    check_word("ref length after reset", 32'h0, data);

    write_reg(REG_CONTROL, 32'h1);
    read_reg(REG_CONTROL, data);
    check_word("control core_rst", 32'h1, data);
    write_reg(REG_CONTROL, 32'h3);
    read_reg(REG_CONTROL, data);
    check_word("control core_rst and run", 32'h3, data);
    // Keep the core in reset for the rest of this test
    write_reg(REG_CONTROL, 32'h1);
    write_reg(REG_REF_LEN, 32'h4d3);
    read_reg(REG_REF_LEN, data);
    check_word("ref length", 32'h4d3, data);

    write_reg(REG_STATUS, 32'hffff_ffff);
    expect_status(1'b0, 1'b0, 1'b1, 1'b0);
    write_reg(REG_VERSION, 32'h0);
    read_reg(REG_VERSION, data);
    check_word("version after write", 32'h1000_0000, data);
    write_reg(REG_KEY, 32'h0);
    read_reg(REG_KEY, data);
    check_word("key after write", 32'h0ca7_cafe, data);

    foreach (bad_idx[i]) begin
        write_reg(bad_idx[i], 32'hdead_beef, AXI_RESP_SLVERR);
        read_reg(bad_idx[i], data, AXI_RESP_SLVERR);
        check_word("unknown index read data", 32'h0, data);
    end
    // Unknown writes must not alias onto real registers
    read_reg(REG_CONTROL, data);
    check_word("control after bad writes", 32'h1, data);
    read_reg(REG_REF_LEN, data);
    check_word("ref length after bad writes", 32'h4d3, data);
endtask

task automatic filtered_load();
    logic [REF_SAMPLE_W-1:0] expected [$];
    logic [REF_SAMPLE_W-1:0] sample;
    logic [AXI_DATA_W-1:0]   data;
    test_name = "filtered load";
    write_reg(REG_REF_LEN, 32'(LONGEST_LOAD));
    write_reg(REG_CONTROL, 32'h1);
    write_reg(REG_CONTROL, 32'h2);
    for (int i = 0; i < LONGEST_LOAD; i++) begin
        data = $random(seed);
        // Channel 1 beats must be swallowed by the filter
        if (data[31] || i == 0) begin
            send_beat(4'd1, data ^ 32'h5a5a_5a5a);
        end
        send_beat(4'd0, data);
        expected.push_back(data[REF_SAMPLE_W-1:0]);
    end
    wait_load_done();
    expect_status(1'b1, 1'b0, 1'b1, 1'b0);
    for (int i = 0; i < LONGEST_LOAD; i++) begin
        read_sample(i, sample);
        check_sample($sformatf("sample %0d", i), expected[i], sample);
    end
endtask

task automatic fifo_back_pressure();
    logic [REF_SAMPLE_W-1:0] expected [$];
    logic [REF_SAMPLE_W-1:0] sample;
    logic [AXI_DATA_W-1:0]   data;
    logic                    accepted;
    int                      count;
    test_name = "back-pressure";
    write_reg(REG_CONTROL, 32'h1);
    write_reg(REG_CONTROL, 32'h0);
    count    = 0;
    accepted = 1'b1;
    // Loader idle, so the FIFO only fills
    while (accepted && count <= SRC_FIFO_DEPTH) begin
        data = $random(seed);
        offer_beat(4'd0, data, accepted);
        if (accepted) begin
            count++;
            expected.push_back(data[REF_SAMPLE_W-1:0]);
        end
    end
    check_word("beats accepted", 32'(SRC_FIFO_DEPTH), 32'(count));
    expect_status(1'b0, 1'b0, 1'b0, 1'b1);

    write_reg(REG_REF_LEN, 32'(SRC_FIFO_DEPTH));
    write_reg(REG_CONTROL, 32'h2);
    wait_load_done();
    expect_status(1'b1, 1'b0, 1'b1, 1'b0);
    for (int i = 0; i < SRC_FIFO_DEPTH; i++) begin
        read_sample(i, sample);
        check_sample($sformatf("sample %0d", i), expected[i], sample);
    end
endtask

task automatic core_reset_load();
    test_name = "core reset";
    expect_status(1'b1, 1'b0, 1'b1, 1'b0);
    // Loader in done state leaves this beat in the FIFO
    send_beat(4'd0, 32'h0000_1234);
    expect_status(1'b1, 1'b0, 1'b0, 1'b0);
    write_reg(REG_CONTROL, 32'h1);
    expect_status(1'b0, 1'b0, 1'b1, 1'b0);

    write_reg(REG_REF_LEN, 32'h0);
    write_reg(REG_CONTROL, 32'h0);
    send_beat(4'd0, 32'h0000_abcd);
    expect_status(1'b0, 1'b0, 1'b0, 1'b0);
    // Zero length completes with the single beat still queued
    write_reg(REG_CONTROL, 32'h2);
    wait_load_done();
    expect_status(1'b1, 1'b0, 1'b0, 1'b0);
endtask

`endif

// ==== verif/tb_dtw_accel.sv ====
// Directed testbench for the single-clock DUT; stops at the first mismatch and samples on negedge
`default_nettype none
`timescale 1ns/1ns

module tb_dtw_accel
    import dtw_accel_pkg::*;
();

    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_TESTS = 5;
    localparam int LONGEST_LOAD = 20;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * (200 + 4 * LONGEST_LOAD);

    logic                  clk;
    logic                  rst;
    logic                  awvalid;
    logic [AXI_ADDR_W-1:0] awaddr;
    logic                  awready;
    logic                  wvalid;
    logic [AXI_DATA_W-1:0] wdata;
    logic                  wready;
    logic                  bvalid;
    logic                  bready;
    logic [1:0]            bresp;
    logic                  arvalid;
    logic [AXI_ADDR_W-1:0] araddr;
    logic                  arready;
    logic                  rvalid;
    logic                  rready;
    logic [1:0]            rresp;
    logic [AXI_DATA_W-1:0] rdata;
    src_beat_t             src_in;
    logic                  src_tready;

    integer seed;
    string  test_name;

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    dtw_accel dut0 (
        .i_S_AXI_clk  (clk),
        .i_w_axi_rst  (rst),
        .i_awvalid    (awvalid),
        .i_awaddr     (awaddr),
        .o_awready    (awready),
        .i_wvalid     (wvalid),
        .i_wdata      (wdata),
        .o_wready     (wready),
        .o_bvalid     (bvalid),
        .i_bready     (bready),
        .o_bresp      (bresp),
        .i_arvalid    (arvalid),
        .i_araddr     (araddr),
        .o_arready    (arready),
        .o_rvalid     (rvalid),
        .i_rready     (rready),
        .o_rresp      (rresp),
        .o_rdata      (rdata),
        .i_src        (src_in),
        .o_src_tready (src_tready)
    );

    task automatic abort_run(input string reason);
        $display("TEST FAILED");
        $fatal(1, "%s", reason);
    endtask

    function automatic logic [AXI_ADDR_W-1:0] word_addr(input logic [3:0] idx);
        return {{(AXI_ADDR_W - 6){1'b0}}, idx, 2'b00};
    endfunction

    // AW and W go out together and bready stays high until the response is taken
    task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr,
                             input logic [AXI_DATA_W-1:0] data, output logic [1:0] resp);
        @(posedge clk);
        awvalid <= 1'b1;
        awaddr  <= addr;
        wvalid  <= 1'b1;
        wdata   <= data;
        bready  <= 1'b1;
        @(negedge clk);
        while (!(awready && wready)) @(negedge clk);
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        resp = bresp;
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr,
                            output logic [AXI_DATA_W-1:0] data, output logic [1:0] resp);
        @(posedge clk);
        arvalid <= 1'b1;
        araddr  <= addr;
        rready  <= 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(posedge clk);
        arvalid <= 1'b0;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        data = rdata;
        resp = rresp;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    // Tready seen at negedge of a one-cycle offer decides the transfer at the next edge
    task automatic offer_beat(input logic [AXIS_DEST_W-1:0] dest,
                              input logic [AXI_DATA_W-1:0] data, output logic accepted);
        @(posedge clk);
        src_in <= '{tvalid: 1'b1, tdest: dest, tdata: data};
        @(negedge clk);
        accepted = src_tready;
        @(posedge clk);
        src_in.tvalid <= 1'b0;
    endtask

    task automatic send_beat(input logic [AXIS_DEST_W-1:0] dest,
                             input logic [AXI_DATA_W-1:0] data);
        logic accepted;
        accepted = 1'b0;
        while (!accepted) offer_beat(dest, data, accepted);
    endtask

    task automatic check_word(input string what, input logic [AXI_DATA_W-1:0] exp,
                              input logic [AXI_DATA_W-1:0] act);
        if (act !== exp) begin
            $display("CHECK FAILED %s, %s: expected %h, actual %h", test_name, what, exp, act);
            abort_run("register data mismatch");
        end
    endtask

    task automatic check_resp(input string what, input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp) begin
            $display("CHECK FAILED %s, %s: expected %b, actual %b", test_name, what, exp, act);
            abort_run("AXI response mismatch");
        end
    endtask

    task automatic check_status(input string what, input status_t exp, input status_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s, %s: expected %b, actual %b", test_name, what, exp, act);
            abort_run("status mismatch");
        end
    endtask

    task automatic check_sample(input string what, input logic [REF_SAMPLE_W-1:0] exp,
                                input logic [REF_SAMPLE_W-1:0] act);
        if (act !== exp) begin
            $display("CHECK FAILED %s, %s: expected %h, actual %h", test_name, what, exp, act);
            abort_run("reference sample mismatch");
        end
    endtask

    task automatic write_reg(input logic [3:0] idx, input logic [AXI_DATA_W-1:0] data,
                             input logic [1:0] exp_resp = AXI_RESP_OKAY);
        logic [1:0] resp;
        axi_write(word_addr(idx), data, resp);
        check_resp($sformatf("write response, index %0d", idx), exp_resp, resp);
    endtask

    task automatic read_reg(input logic [3:0] idx, output logic [AXI_DATA_W-1:0] data,
                            input logic [1:0] exp_resp = AXI_RESP_OKAY);
        logic [1:0] resp;
        axi_read(word_addr(idx), data, resp);
        check_resp($sformatf("read response, index %0d", idx), exp_resp, resp);
    endtask

    task automatic read_status(output status_t st);
        logic [AXI_DATA_W-1:0] data;
        read_reg(REG_STATUS, data);
        check_word("status upper bits", 32'h0, data & 32'hffff_fff0);
        st = status_t'(data[3:0]);
    endtask

    task automatic expect_status(input logic done, input logic busy,
                                 input logic empty, input logic full);
        status_t exp;
        status_t act;
        exp.load_done   = done;
        exp.loader_busy = busy;
        exp.fifo_empty  = empty;
        exp.fifo_full   = full;
        read_status(act);
        check_status("status", exp, act);
    endtask

    task automatic wait_load_done();
        status_t st;
        st = '0;
        while (!st.load_done) read_status(st);
    endtask

    // Writes the debug address first and then reads the zero-extended memory word
    task automatic read_sample(input int addr, output logic [REF_SAMPLE_W-1:0] sample);
        logic [AXI_DATA_W-1:0] data;
        write_reg(REG_REF_ADDR, 32'(addr));
        read_reg(REG_REF_DOUT, data);
        check_word("ref dout upper bits", 32'h0, data & 32'hffff_0000);
        sample = data[REF_SAMPLE_W-1:0];
    endtask

    `include "dtw_accel_tests.svh"

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: tests still running after %0d clock cycles", WATCHDOG_CYCLES);
        abort_run("watchdog expired");
    end

    initial begin
        seed      = 32'h83fd;
        test_name = "reset";
        rst       <= 1'b1;
        awvalid   <= 1'b0;
        awaddr    <= '0;
        wvalid    <= 1'b0;
        wdata     <= '0;
        bready    <= 1'b0;
        arvalid   <= 1'b0;
        araddr    <= '0;
        rready    <= 1'b0;
        src_in    <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        verify_identity();
        register_access();
        filtered_load();
        fifo_back_pressure();
        core_reset_load();

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dtw_accel.f ====
+incdir+verif
hw/dtw_accel_pkg.sv
hw/axi_lite_reg_slave.sv
hw/dtw_reg_file.sv
hw/src_stream_fifo.sv
hw/ref_mem_loader.sv
hw/dtw_accel.sv
verif/tb_dtw_accel.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it, the exit status tells pass or fail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns \
    --top-module tb_dtw_accel -f dtw_accel.f -o tb_dtw_accel
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/tb_dtw_accel
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit "$status"
fi
exit 0
